// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --assert -Wno-fatal
TOP      = pbs_part3_tb
FILELIST = all.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run check clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) +verilator+error+limit+100 > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "test passed" $(LOG)

check:
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== all.f ====
verilog/pbs_part3_pkg.sv
verilog/bsk_key_cache.sv
verilog/ntt_key_mult.sv
verilog/pep_status_merge.sv
verilog/pbs_part3_core.sv
testbench/tb_clock_gen.sv
testbench/pbs_part3_asserts.sv
testbench/pbs_part3_tb.sv

// ==== testbench/pbs_part3_asserts.sv ====
// Concurrent assertions on the third partition core
// Reset flush, cache clear done timing, pipeline latency
// Sticky status bits
module pbs_part3_asserts
  import pbs_part3_pkg::*;
(
  input logic             prc_clk,
  input logic             prc_srst_n,
  input logic             cache_reset,
  input logic             cache_reset_done,
  input logic             prev_avail,
  input logic             next_avail,
  input logic [err_w-1:0] status_error
);

  // Failed assertions so far
  int unsigned fail_count = 0;

  // Pipeline flushed by a reset cycle
  reset_flush: assert property (@(posedge prc_clk) !prc_srst_n |=> !next_avail)
    else begin
      $error("next_avail high after a reset cycle");
      fail_count++;
    end

  // Done pulse one cycle after the clear strobe
  clear_done: assert property (@(posedge prc_clk) disable iff (!prc_srst_n)
    cache_reset_done == $past(cache_reset))
    else begin
      $error("cache_reset_done does not follow cache_reset");
      fail_count++;
    end

  // Fixed latency, whatever the traffic
  avail_delay: assert property (@(posedge prc_clk) disable iff (!prc_srst_n)
    next_avail == $past(prev_avail, mult_latency))
    else begin
      $error("next_avail does not follow prev_avail by the pipeline latency");
      fail_count++;
    end

  // Error bits only clear on reset
  sticky_err: assert property (@(posedge prc_clk) disable iff (!prc_srst_n)
    ($past(status_error) & ~status_error) == err_w'(0))
    else begin
      $error("status_error bit fell outside reset");
      fail_count++;
    end

endmodule

bind pbs_part3_core pbs_part3_asserts pbs_part3_asserts_inst (
  .prc_clk          (prc_clk),
  .prc_srst_n       (prc_srst_n),
  .cache_reset      (cache_reset),
  .cache_reset_done (cache_reset_done),
  .prev_avail       (prev_avail),
  .next_avail       (next_avail),
  .status_error     (status_error)
);

// ==== testbench/pbs_part3_tb.sv ====
// Testbench of the third bootstrapping partition
// Galois LFSR stimulus, key cache and command queue model
// Expected-output queue with arrival cycle and marker checks
// Status, batch count and cache clear checks, closing report
module pbs_part3_tb
  import pbs_part3_pkg::*;
();

  typedef struct packed {
    logic [31:0]         due;
    logic [coef_w-1:0]   data;
    logic                sob;
    logic                eob;
    logic [pbs_id_w-1:0] id;
  } exp_t;

  typedef struct packed {
    logic [key_addr_w-1:0] base;
    logic [cmd_len_w-1:0]  len;
  } cmd_t;

  logic                   prc_clk;
  logic                   prc_srst_n;
  logic                   reset_req;
  logic                   cmd_avail;
  logic [key_addr_w-1:0]  cmd_key_base;
  logic [cmd_len_w-1:0]   cmd_len;
  logic                   prev_avail;
  logic [coef_w-1:0]      prev_data;
  logic                   prev_sob;
  logic                   prev_eob;
  logic [pbs_id_w-1:0]    prev_pbs_id;
  logic                   key_wr;
  logic [key_addr_w-1:0]  key_wr_addr;
  logic [coef_w-1:0]      key_wr_data;
  logic                   cache_reset;
  logic                   next_avail;
  logic [coef_w-1:0]      next_data;
  logic                   next_sob;
  logic                   next_eob;
  logic [pbs_id_w-1:0]    next_pbs_id;
  logic                   cache_reset_done;
  logic [err_w-1:0]       status_error;
  logic [batch_cnt_w-1:0] batch_count;

  // ==================================================
  // Model state
  // ==================================================
  logic [coef_w-1:0]    m_keys [key_depth];
  logic [key_depth-1:0] m_loaded;
  cmd_t                 cmd_q [$];
  exp_t                 exp_q [$];
  // Position within the current batch
  int                   m_pos;
  logic [err_w-1:0]     exp_err;
  int                   eob_seen;
  logic [31:0]          cyc;
  logic [31:0]          lfsr;
  int                   check_errs;
  int                   timeout_errs;

  tb_clock_gen tb_clock_gen_inst (
    .reset_req  (reset_req),
    .prc_clk    (prc_clk),
    .prc_srst_n (prc_srst_n)
  );

  pbs_part3_core pbs_part3_core_inst (.*);

  always @(posedge prc_clk) begin
    cyc <= cyc + 32'd1;
  end

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per returned bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Next drive slot, strobes drop back to zero
  task automatic tick();
    @(posedge prc_clk);
    #10;
    cmd_avail   = 1'b0;
    prev_avail  = 1'b0;
    prev_sob    = 1'b0;
    prev_eob    = 1'b0;
    key_wr      = 1'b0;
    cache_reset = 1'b0;
  endtask

  // ==================================================
  // Stimulus with model update
  // ==================================================
  // A write together with a clear is dropped
  task automatic write_key(input int addr, input logic [coef_w-1:0] data, input logic clear);
    tick();
    key_wr      = 1'b1;
    key_wr_addr = key_addr_w'(addr);
    key_wr_data = data;
    cache_reset = clear;
    if (clear) begin
      m_loaded = '0;
    end else begin
      m_keys[addr]   = data;
      m_loaded[addr] = 1'b1;
    end
  endtask

  task automatic push_cmd(input logic [key_addr_w-1:0] base, input logic [cmd_len_w-1:0] len);
    cmd_t c;
    tick();
    cmd_avail    = 1'b1;
    cmd_key_base = base;
    cmd_len      = len;
    c.base = base;
    c.len  = len;
    if (cmd_q.size() >= cmd_fifo_depth) begin
      exp_err[err_cmd_overflow] = 1'b1;
    end else begin
      cmd_q.push_back(c);
    end
  endtask

  task automatic send_coef(input logic [coef_w-1:0] data, input logic sob, input logic eob,
                           input logic [pbs_id_w-1:0] id);
    exp_t e;
    int   idx;
    logic last;
    tick();
    prev_avail  = 1'b1;
    prev_data   = data;
    prev_sob    = sob;
    prev_eob    = eob;
    prev_pbs_id = id;
    // Seen mult_latency edges after this drive slot
    e.due = cyc + 32'(mult_latency);
    e.sob = sob;
    e.eob = eob;
    e.id  = id;
    if (cmd_q.size() == 0) begin
      e.data = '0;
      exp_err[err_cmd_missing] = 1'b1;
    end else begin
      // Key index wraps at the cache depth
      idx = (int'(cmd_q[0].base) + m_pos) % key_depth;
      if (m_loaded[idx]) begin
        e.data = coef_w'((longint'(data) * longint'(m_keys[idx])) % mod_q);
      end else begin
        e.data = '0;
        exp_err[err_key_unloaded] = 1'b1;
      end
      last = (m_pos + 1 == int'(cmd_q[0].len));
      if (eob != last) exp_err[err_len_mismatch] = 1'b1;
      if (last || eob) begin
        void'(cmd_q.pop_front());
        m_pos = 0;
      end else begin
        m_pos++;
      end
    end
    exp_q.push_back(e);
  endtask

  // Coefficients up to eob_at, with gaps of zero to two cycles
  task automatic send_coefs(input int eob_at, input logic [pbs_id_w-1:0] id);
    int gap;
    for (int p = 0; p <= eob_at; p++) begin
      gap = int'(take_bits(2)) % 3;
      repeat (gap) tick();
      send_coef(coef_w'(take_bits(coef_w)), p == 0, p == eob_at, id);
    end
  endtask

  // ==================================================
  // Checks
  // ==================================================
  always @(negedge prc_clk) begin
    exp_t e;
    if (prc_srst_n && next_avail) begin
      if (exp_q.size() == 0) begin
        $display("Output strobe with no expected output at cycle %0d", cyc);
        check_errs++;
      end else begin
        e = exp_q.pop_front();
        if (next_data !== e.data) begin
          $display("Fail next_data exp %h got %h", e.data, next_data);
          check_errs++;
        end
        if (next_sob !== e.sob) begin
          $display("Fail next_sob exp %h got %h", e.sob, next_sob);
          check_errs++;
        end
        if (next_eob !== e.eob) begin
          $display("Fail next_eob exp %h got %h", e.eob, next_eob);
          check_errs++;
        end
        if (next_pbs_id !== e.id) begin
          $display("Fail next_pbs_id exp %h got %h", e.id, next_pbs_id);
          check_errs++;
        end
        if (cyc !== e.due) begin
          $display("Fail next_avail cycle exp %h got %h", e.due, cyc);
          check_errs++;
        end
        if (e.eob) eob_seen++;
      end
    end
  end

  task automatic finish_run();
    int asrt;
    asrt = int'(pbs_part3_core_inst.pbs_part3_asserts_inst.fail_count);
    $display("Errors: %0d check, %0d timeout, %0d assertion", check_errs, timeout_errs, asrt);
    if (check_errs + timeout_errs + asrt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  // Wait until every expected output came out
  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 50) begin
      tick();
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout, %0d expected outputs never arrived", exp_q.size());
      timeout_errs++;
    end
    repeat (2) tick();
  endtask

  task automatic check_status();
    drain();
    if (status_error !== exp_err) begin
      $display("Fail status_error exp %h got %h", exp_err, status_error);
      check_errs++;
    end
    if (batch_count !== batch_cnt_w'(eob_seen)) begin
      $display("Fail batch_count exp %h got %h", batch_cnt_w'(eob_seen), batch_count);
      check_errs++;
    end
  endtask

  // Clear done must pulse for exactly one cycle
  task automatic wait_cache_done();
    int n;
    n = 0;
    while (cache_reset_done !== 1'b1 && n < 10) begin
      tick();
      n++;
    end
    if (cache_reset_done !== 1'b1) begin
      $display("Timeout, cache_reset_done never pulsed");
      timeout_errs++;
    end else begin
      tick();
      if (cache_reset_done !== 1'b0) begin
        $display("Fail cache_reset_done exp %h got %h", 1'b0, cache_reset_done);
        check_errs++;
      end
    end
  endtask

  task automatic check_idle();
    tick();
    if (next_avail !== 1'b0) begin
      $display("Fail next_avail exp %h got %h", 1'b0, next_avail);
      check_errs++;
    end
    if (cache_reset_done !== 1'b0) begin
      $display("Fail cache_reset_done exp %h got %h", 1'b0, cache_reset_done);
      check_errs++;
    end
    if (status_error !== '0) begin
      $display("Fail status_error exp %h got %h", err_w'(0), status_error);
      check_errs++;
    end
    if (batch_count !== '0) begin
      $display("Fail batch_count exp %h got %h", batch_cnt_w'(0), batch_count);
      check_errs++;
    end
  endtask

  // Reset clears the queue, the loaded flags and the status
  task automatic apply_reset();
    tick();
    reset_req = 1'b1;
    repeat (10) tick();
    reset_req = 1'b0;
    cmd_q.delete();
    exp_q.delete();
    m_pos    = 0;
    m_loaded = '0;
    exp_err  = '0;
    eob_seen = 0;
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    int                    n;
    logic [cmd_len_w-1:0]  len;
    logic [cmd_len_w-1:0]  lens [5];
    cmd_avail    = 1'b0;
    cmd_key_base = '0;
    cmd_len      = '0;
    prev_avail   = 1'b0;
    prev_data    = '0;
    prev_sob     = 1'b0;
    prev_eob     = 1'b0;
    prev_pbs_id  = '0;
    key_wr       = 1'b0;
    key_wr_addr  = '0;
    key_wr_data  = '0;
    cache_reset  = 1'b0;
    reset_req    = 1'b0;
    cyc          = '0;
    lfsr         = 32'd89525;
    m_pos        = 0;
    m_loaded     = '0;
    exp_err      = '0;
    eob_seen     = 0;
    check_errs   = 0;
    timeout_errs = 0;

    // Power-on reset
    n = 0;
    while (prc_srst_n !== 1'b1 && n < 30) begin
      @(posedge prc_clk);
      n++;
    end
    if (prc_srst_n !== 1'b1) begin
      $display("Timeout, reset was never released");
      timeout_errs++;
    end
    check_idle();

    // Full key load, then legal random batches
    for (int a = 0; a < key_depth; a++) begin
      write_key(a, coef_w'(take_bits(coef_w)), 1'b0);
    end
    for (int b = 0; b < 12; b++) begin
      len = cmd_len_w'(take_bits(cmd_len_w));
      if (len == '0) len = 1;
      push_cmd(key_addr_w'(take_bits(key_addr_w)), len);
      send_coefs(int'(len) - 1, pbs_id_w'(take_bits(pbs_id_w)));
    end
    check_status();

    // Cache clear with a write in the same cycle to a word the batch reads
    write_key(8 + int'(take_bits(2)), coef_w'(take_bits(coef_w)), 1'b1);
    wait_cache_done();
    for (int a = 0; a < 8; a++) begin
      write_key(a, coef_w'(take_bits(coef_w)), 1'b0);
    end
    push_cmd(4'd4, 5'd8);
    send_coefs(7, pbs_id_w'(take_bits(pbs_id_w)));
    check_status();

    // Coefficient with no command queued
    send_coef(coef_w'(take_bits(coef_w)), 1'b1, 1'b1, pbs_id_w'(take_bits(pbs_id_w)));
    check_status();

    // Five commands back to back, the last one dropped
    for (int a = 0; a < 8; a++) begin
      write_key(a, coef_w'(take_bits(coef_w)), 1'b0);
    end
    for (int c = 0; c < 5; c++) begin
      lens[c] = cmd_len_w'(take_bits(3)) + 5'd1;
      push_cmd(key_addr_w'(take_bits(2)), lens[c]);
    end
    for (int c = 0; c < 4; c++) begin
      send_coefs(int'(lens[c]) - 1, pbs_id_w'(c));
    end
    // Early eob
    push_cmd(key_addr_w'(take_bits(2)), 5'd6);
    send_coefs(2, pbs_id_w'(take_bits(pbs_id_w)));
    check_status();

    // Reset with the multiply pipeline still full
    for (int c = 0; c < mult_latency; c++) begin
      send_coef(coef_w'(take_bits(coef_w)), 1'b1, 1'b1, pbs_id_w'(take_bits(pbs_id_w)));
    end
    apply_reset();
    check_idle();
    finish_run();
  end

endmodule

// ==== testbench/tb_clock_gen.sv ====
// Clock and reset source of the testbench
// 100-unit clock, reset held for the first 10 edges
// Reset also held while reset_req is high
module tb_clock_gen (
  input  logic reset_req,
  output logic prc_clk,
  output logic prc_srst_n
);

  // Edges seen since time zero, saturates at 10
  logic [3:0] por_cnt;

  initial begin
    prc_clk = 1'b0;
    por_cnt = '0;
    forever #50 prc_clk = ~prc_clk;
  end

  always @(posedge prc_clk) begin
    if (por_cnt != 4'd10) begin
      por_cnt <= por_cnt + 4'd1;
    end
  end

  assign prc_srst_n = (por_cnt == 4'd10) && !reset_req;

endmodule

// ==== verilog/bsk_key_cache.sv ====
// Bootstrapping key cache
// Key word storage with one loaded flag per word
// Write strobe port and registered read port
// Cache clear strobe with a one-cycle done pulse
// Unloaded-read error pulse
module bsk_key_cache
  import pbs_part3_pkg::*;
(
  input  logic                  prc_clk,
  input  logic                  prc_srst_n,
  // Key load
  input  logic                  key_wr,
  input  logic [key_addr_w-1:0] key_wr_addr,
  input  logic [coef_w-1:0]     key_wr_data,
  // Cache clear
  input  logic                  cache_reset,
  output logic                  cache_reset_done,
  // Read port, data one cycle after key_rd
  input  logic                  key_rd,
  input  logic [key_addr_w-1:0] key_rd_addr,
  output logic [coef_w-1:0]     key_rd_data,
  output logic                  key_rd_loaded,
  // Error pulses
  output logic [err_w-1:0]      key_error
);

  // ==================================================
  // Storage
  // ==================================================
  logic [coef_w-1:0]    key_mem [key_depth];
  logic [key_depth-1:0] loaded;
  // Read issued last cycle
  logic                 rd_pend;

  // Key words, a write during cache clear is dropped
  always_ff @(posedge prc_clk) begin
    if (key_wr && !cache_reset) begin
      key_mem[key_wr_addr] <= key_wr_data;
    end
  end

  // Loaded flags
  // Clear wins over a write in the same cycle
  always_ff @(posedge prc_clk) begin
    if (!prc_srst_n) begin
      loaded <= '0;
    end else if (cache_reset) begin
      loaded <= '0;
    end else if (key_wr) begin
      loaded[key_wr_addr] <= 1'b1;
    end
  end

  // Clear completes in one cycle
  always_ff @(posedge prc_clk) begin
    if (!prc_srst_n) begin
      cache_reset_done <= 1'b0;
    end else begin
      cache_reset_done <= cache_reset;
    end
  end

  // ==================================================
  // Read port
  // ==================================================
  always_ff @(posedge prc_clk) begin
    if (!prc_srst_n) begin
      rd_pend       <= 1'b0;
      key_rd_loaded <= 1'b0;
    end else begin
      rd_pend       <= key_rd;
      key_rd_loaded <= key_rd && loaded[key_rd_addr];
    end
  end

  // Unloaded words read back as zero
  always_ff @(posedge prc_clk) begin
    if (key_rd) begin
      key_rd_data <= loaded[key_rd_addr] ? key_mem[key_rd_addr] : '0;
    end
  end

  // Pulse aligned with the returned word
  always_comb begin
    key_error = '0;
    key_error[err_key_unloaded] = rd_pend && !key_rd_loaded;
  end

endmodule

// ==== verilog/ntt_key_mult.sv ====
// Key multiply stage of the third partition
// Batch command queue and batch position tracking
// Key index sequencing towards the key cache
// Three-stage modular multiply with delayed batch markers
// Command and length error pulses, batch done pulse
module ntt_key_mult
  import pbs_part3_pkg::*;
(
  input  logic                  prc_clk,
  input  logic                  prc_srst_n,
  // Batch command
  input  logic                  cmd_avail,
  input  logic [key_addr_w-1:0] cmd_key_base,
  input  logic [cmd_len_w-1:0]  cmd_len,
  // Previous partition
  input  logic                  prev_avail,
  input  logic [coef_w-1:0]     prev_data,
  input  logic                  prev_sob,
  input  logic                  prev_eob,
  input  logic [pbs_id_w-1:0]   prev_pbs_id,
  // Key cache
  output logic                  key_rd,
  output logic [key_addr_w-1:0] key_rd_addr,
  input  logic [coef_w-1:0]     key_rd_data,
  // Next partition
  output logic                  next_avail,
  output logic [coef_w-1:0]     next_data,
  output logic                  next_sob,
  output logic                  next_eob,
  output logic [pbs_id_w-1:0]   next_pbs_id,
  // Status
  output logic [err_w-1:0]      mult_error,
  output logic                  batch_done_pulse
);

  // Fold the upper half twice with 2^16 = mod_fold, then one subtract
  function automatic logic [coef_w-1:0] mod_reduce(input logic [2*coef_w-1:0] x);
    logic [coef_w+3:0] f1;
    logic [coef_w:0]   f2;
    f1 = (coef_w+4)'(x[2*coef_w-1:coef_w]) * (coef_w+4)'(mod_fold)
         + (coef_w+4)'(x[coef_w-1:0]);
    f2 = (coef_w+1)'(f1[coef_w+3:coef_w]) * (coef_w+1)'(mod_fold)
         + (coef_w+1)'(f1[coef_w-1:0]);
    // f2 is below 2 * mod_q here
    return (f2 >= (coef_w+1)'(mod_q)) ? coef_w'(f2 - (coef_w+1)'(mod_q)) : f2[coef_w-1:0];
  endfunction

  // ==================================================
  // Command queue
  // ==================================================
  logic [key_addr_w-1:0] q_base [cmd_fifo_depth];
  logic [cmd_len_w-1:0]  q_len  [cmd_fifo_depth];
  logic [cmd_ptr_w-1:0]  wr_ptr;
  logic [cmd_ptr_w-1:0]  rd_ptr;
  logic [cmd_ptr_w:0]    q_cnt;
  logic                  q_full;
  logic                  q_empty;
  logic                  q_push;
  logic                  q_pop;

  assign q_full  = (q_cnt == (cmd_ptr_w+1)'(cmd_fifo_depth));
  assign q_empty = (q_cnt == '0);
  // Commands into a full queue are dropped
  assign q_push  = cmd_avail && !q_full;

  always_ff @(posedge prc_clk) begin
    if (q_push) begin
      q_base[wr_ptr] <= cmd_key_base;
      q_len[wr_ptr]  <= cmd_len;
    end
  end

  always_ff @(posedge prc_clk) begin
    if (!prc_srst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      q_cnt  <= '0;
    end else begin
      if (q_push) wr_ptr <= wr_ptr + 1'b1;
      if (q_pop) rd_ptr <= rd_ptr + 1'b1;
      q_cnt <= q_cnt + (cmd_ptr_w+1)'(q_push) - (cmd_ptr_w+1)'(q_pop);
    end
  end

  // ==================================================
  // Batch position and key read
  // ==================================================
  logic [cmd_len_w-1:0] pos;
  logic [cmd_len_w-1:0] pos_inc;
  logic                 coef_hit;
  logic                 at_last;

  // Coefficient with a queued command
  assign coef_hit = prev_avail && !q_empty;
  assign pos_inc  = pos + 1'b1;
  assign at_last  = (pos_inc == q_len[rd_ptr]);
  // Retire at the last coefficient, or early on eob
  assign q_pop    = coef_hit && (at_last || prev_eob);

  always_ff @(posedge prc_clk) begin
    if (!prc_srst_n) begin
      pos <= '0;
    end else if (q_pop) begin
      pos <= '0;
    end else if (coef_hit) begin
      pos <= pos_inc;
    end
  end

  // Stage one, index wraps at key_depth
  assign key_rd      = coef_hit;
  assign key_rd_addr = q_base[rd_ptr] + pos[key_addr_w-1:0];

  // ==================================================
  // Multiply pipeline
  // ==================================================
  logic [mult_latency-1:0] avail_pipe;
  logic [mult_latency-1:0] sob_pipe;
  logic [mult_latency-1:0] eob_pipe;
  logic [pbs_id_w-1:0]     id_pipe [mult_latency];
  logic [coef_w-1:0]       s1_coef;
  logic                    s1_hit;
  logic [2*coef_w-1:0]     s2_prod;

  always_ff @(posedge prc_clk) begin
    if (!prc_srst_n) begin
      avail_pipe <= '0;
    end else begin
      avail_pipe <= {avail_pipe[mult_latency-2:0], prev_avail};
    end
  end

  // Markers ride along unchanged
  always_ff @(posedge prc_clk) begin
    sob_pipe   <= {sob_pipe[mult_latency-2:0], prev_sob};
    eob_pipe   <= {eob_pipe[mult_latency-2:0], prev_eob};
    id_pipe[0] <= prev_pbs_id;
    for (int i = 1; i < mult_latency; i++) begin
      id_pipe[i] <= id_pipe[i-1];
    end
  end

  // Stage two full product, stage three reduced result
  // No command gives a zero product
  always_ff @(posedge prc_clk) begin
    s1_coef   <= prev_data;
    s1_hit    <= coef_hit;
    s2_prod   <= s1_hit ? s1_coef * key_rd_data : '0;
    next_data <= mod_reduce(s2_prod);
  end

  assign next_avail  = avail_pipe[mult_latency-1];
  assign next_sob    = sob_pipe[mult_latency-1];
  assign next_eob    = eob_pipe[mult_latency-1];
  assign next_pbs_id = id_pipe[mult_latency-1];

  // ==================================================
  // Status
  // ==================================================
  assign batch_done_pulse = next_avail && next_eob;

  always_comb begin
    mult_error = '0;
    mult_error[err_cmd_missing]  = prev_avail && q_empty;
    mult_error[err_cmd_overflow] = cmd_avail && q_full;
    mult_error[err_len_mismatch] = coef_hit && (prev_eob != at_last);
  end

endmodule

// ==== verilog/pbs_part3_core.sv ====
// Top level of the third bootstrapping partition
// Key cache, key multiply pipeline and status merge
// Block error vectors routed to the status merge
module pbs_part3_core
  import pbs_part3_pkg::*;
(
  input  logic                   prc_clk,
  input  logic                   prc_srst_n,
  // Batch command
  input  logic                   cmd_avail,
  input  logic [key_addr_w-1:0]  cmd_key_base,
  input  logic [cmd_len_w-1:0]   cmd_len,
  // Previous partition
  input  logic                   prev_avail,
  input  logic [coef_w-1:0]      prev_data,
  input  logic                   prev_sob,
  input  logic                   prev_eob,
  input  logic [pbs_id_w-1:0]    prev_pbs_id,
  // Key load and cache clear
  input  logic                   key_wr,
  input  logic [key_addr_w-1:0]  key_wr_addr,
  input  logic [coef_w-1:0]      key_wr_data,
  input  logic                   cache_reset,
  // Next partition
  output logic                   next_avail,
  output logic [coef_w-1:0]      next_data,
  output logic                   next_sob,
  output logic                   next_eob,
  output logic [pbs_id_w-1:0]    next_pbs_id,
  // Status
  output logic                   cache_reset_done,
  output logic [err_w-1:0]       status_error,
  output logic [batch_cnt_w-1:0] batch_count
);

  // Key read path
  logic                  key_rd;
  logic [key_addr_w-1:0] key_rd_addr;
  logic [coef_w-1:0]     key_rd_data;
  // Block status
  logic [err_w-1:0]      key_error;
  logic [err_w-1:0]      mult_error;
  logic                  batch_done_pulse;

  // ==================================================
  // Key cache
  // ==================================================
  bsk_key_cache bsk_key_cache_inst (
    .prc_clk          (prc_clk),
    .prc_srst_n       (prc_srst_n),
    .key_wr           (key_wr),
    .key_wr_addr      (key_wr_addr),
    .key_wr_data      (key_wr_data),
    .cache_reset      (cache_reset),
    .cache_reset_done (cache_reset_done),
    .key_rd           (key_rd),
    .key_rd_addr      (key_rd_addr),
    .key_rd_data      (key_rd_data),
    // Loaded flag is already folded into key_error
    .key_rd_loaded    (),
    .key_error        (key_error)
  );

  // Multiply pipeline
  ntt_key_mult ntt_key_mult_inst (
    .prc_clk          (prc_clk),
    .prc_srst_n       (prc_srst_n),
    .cmd_avail        (cmd_avail),
    .cmd_key_base     (cmd_key_base),
    .cmd_len          (cmd_len),
    .prev_avail       (prev_avail),
    .prev_data        (prev_data),
    .prev_sob         (prev_sob),
    .prev_eob         (prev_eob),
    .prev_pbs_id      (prev_pbs_id),
    .key_rd           (key_rd),
    .key_rd_addr      (key_rd_addr),
    .key_rd_data      (key_rd_data),
    .next_avail       (next_avail),
    .next_data        (next_data),
    .next_sob         (next_sob),
    .next_eob         (next_eob),
    .next_pbs_id      (next_pbs_id),
    .mult_error       (mult_error),
    .batch_done_pulse (batch_done_pulse)
  );

  // Status side logic
  pep_status_merge pep_status_merge_inst (
    .prc_clk          (prc_clk),
    .prc_srst_n       (prc_srst_n),
    .key_error        (key_error),
    .mult_error       (mult_error),
    .batch_done_pulse (batch_done_pulse),
    .status_error     (status_error),
    .batch_count      (batch_count)
  );

endmodule

// ==== verilog/pbs_part3_pkg.sv ====
// Shared constants of the third bootstrapping partition
// Coefficient and key widths, prime modulus and folding constant
// Key cache and command queue sizes
// Error vector bit positions and multiply pipeline latency
package pbs_part3_pkg;

  // ==================================================
  // Datapath
  // ==================================================
  // Coefficient and key word width
  localparam int coef_w = 16;
  // Largest prime below 2^16
  localparam int mod_q = 65521;
  // 2^coef_w mod mod_q, drives the folding reduction
  localparam int mod_fold = (1 << coef_w) - mod_q;
  // Coefficient strobe to output strobe
  localparam int mult_latency = 3;

  // Key cache
  localparam int key_depth = 16;
  localparam int key_addr_w = 4;

  // Batch commands
  localparam int pbs_id_w = 4;
  // Batch length, 1 to 31 coefficients
  localparam int cmd_len_w = 5;
  localparam int cmd_fifo_depth = 4;
  localparam int cmd_ptr_w = $clog2(cmd_fifo_depth);
  localparam int batch_cnt_w = 16;

  // ==================================================
  // Error vector
  // ==================================================
  localparam int err_w = 4;
  localparam int err_cmd_missing = 0;
  localparam int err_cmd_overflow = 1;
  localparam int err_key_unloaded = 2;
  localparam int err_len_mismatch = 3;

endpackage

// ==== verilog/pep_status_merge.sv ====
// Status side logic of the third partition
// Registered OR-merge of the block error pulses into a sticky vector
// Wrapping counter of completed batches
module pep_status_merge
  import pbs_part3_pkg::*;
(
  input  logic                   prc_clk,
  input  logic                   prc_srst_n,
  // Error pulses of the blocks
  input  logic [err_w-1:0]       key_error,
  input  logic [err_w-1:0]       mult_error,
  // Event pulse
  input  logic                   batch_done_pulse,
  // Status
  output logic [err_w-1:0]       status_error,
  output logic [batch_cnt_w-1:0] batch_count
);

  // Combined pulses of this cycle
  logic [err_w-1:0] error_merged;

  assign error_merged = key_error | mult_error;

  // ==================================================
  // Sticky errors
  // ==================================================
  // Bits only clear on reset
  always_ff @(posedge prc_clk) begin
    if (!prc_srst_n) begin
      status_error <= '0;
    end else begin
      status_error <= status_error | error_merged;
    end
  end

  // Batch counter, wraps at 2^16
  always_ff @(posedge prc_clk) begin
    if (!prc_srst_n) begin
      batch_count <= '0;
    end else if (batch_done_pulse) begin
      batch_count <= batch_count + 1'b1;
    end
  end

endmodule
